// ==== Makefile ====
TOP := rvCoreTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module rvCore

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

// ==== filelist.f ====
+incdir+logic
+incdir+test
logic/rv_pkg.sv
logic/decoder.sv
logic/regFile.sv
logic/alu.sv
logic/dataMem.sv
logic/rvCore.sv
test/rvCoreTb.sv

// ==== logic/alu.sv ====
`default_nettype none
`timescale 1ns/1ps

module alu (
  input  rv_pkg::Word    a,
  input  rv_pkg::Word    b,
  input  rv_pkg::AluFunc func,
  output rv_pkg::Word    result
);
  logic [4:0] shamt;

  // shifts only look at the low five bits
  assign shamt = b[4:0];

  always_comb begin
    case (func)
      rv_pkg::ADD:  result = a + b;
      rv_pkg::SUB:  result = a - b;
      rv_pkg::AND:  result = a & b;
      rv_pkg::OR:   result = a | b;
      rv_pkg::XOR:  result = a ^ b;
      rv_pkg::SLT:  result = {31'b0, $signed(a) < $signed(b)};
      rv_pkg::SLTU: result = {31'b0, a < b};
      rv_pkg::SLL:  result = a << shamt;
      rv_pkg::SRL:  result = a >> shamt;
      // arithmetic shift keeps the sign
      rv_pkg::SRA:  result = $signed(a) >>> shamt;
      default:      result = '0;
    endcase
  end
endmodule

`default_nettype wire

// ==== logic/dataMem.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "rv_config.svh"

module dataMem (
  input  wire            clk,
  input  rv_pkg::Word    addr,
  input  rv_pkg::Word    wrData,
  input  rv_pkg::MemFunc memFunc,
  input  wire            wrEn,
  output rv_pkg::Word    rdData
);
  localparam int IdxW = $clog2(`RV_DMEM_WORDS);

  rv_pkg::Word mem [`RV_DMEM_WORDS];
  logic [IdxW-1:0] idx;
  rv_pkg::Word word;
  logic [7:0] byteLane;
  logic [15:0] halfLane;
  logic [3:0] byteEn;
  rv_pkg::Word wrWord;

  // upper address bits wrap
  assign idx = addr[IdxW+1:2];
  assign word = mem[idx];
  assign byteLane = word[{addr[1:0], 3'b000} +: 8];
  assign halfLane = addr[1] ? word[31:16] : word[15:0];

  always_comb begin
    case (memFunc)
      rv_pkg::LB:  rdData = {{24{byteLane[7]}}, byteLane};
      rv_pkg::LBU: rdData = {24'b0, byteLane};
      rv_pkg::LH:  rdData = {{16{halfLane[15]}}, halfLane};
      rv_pkg::LHU: rdData = {16'b0, halfLane};
      default:     rdData = word;
    endcase
  end

  // replicate the lane, enables pick where it lands
  always_comb begin
    case (memFunc)
      rv_pkg::SB: begin
        byteEn = 4'b0001 << addr[1:0];
        wrWord = {4{wrData[7:0]}};
      end
      rv_pkg::SH: begin
        byteEn = addr[1] ? 4'b1100 : 4'b0011;
        wrWord = {2{wrData[15:0]}};
      end
      default: begin
        byteEn = 4'b1111;
        wrWord = wrData;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (wrEn) begin
      for (int b = 0; b < 4; b++) begin
        if (byteEn[b]) begin
          mem[idx][8*b +: 8] <= wrWord[8*b +: 8];
        end
      end
    end
  end

  wrOnlyOnStore: assert property (@(posedge clk)
    wrEn |-> memFunc inside {rv_pkg::SW, rv_pkg::SH, rv_pkg::SB});
endmodule

`default_nettype wire

// ==== logic/decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module decoder (
  input  wire rv_pkg::Word inst,
  output rv_pkg::DecodedInst dinst
);
  rv_pkg::Opcode opcode;
  rv_pkg::Funct3 funct3;
  logic [6:0] funct7;
  rv_pkg::RegIdx dst;
  rv_pkg::RegIdx src1;
  rv_pkg::RegIdx src2;

  // sign-extended immediates
  rv_pkg::Word immI;
  rv_pkg::Word immS;
  rv_pkg::Word immB;
  rv_pkg::Word immU;
  rv_pkg::Word immJ;

  assign opcode = rv_pkg::Opcode'(inst[6:0]);
  assign funct3 = rv_pkg::Funct3'(inst[14:12]);
  assign funct7 = inst[31:25];
  assign dst = inst[11:7];
  assign src1 = inst[19:15];
  assign src2 = inst[24:20];

  assign immI = {{20{inst[31]}}, inst[31:20]};
  assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  // U-type already fills all 32 bits
  assign immU = {inst[31:12], 12'b0};
  assign immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // shared by OP and OPIMM; alt selects SUB / SRA
  function automatic rv_pkg::AluFunc aluOf(input rv_pkg::Funct3 f3, input logic alt);
    case (f3)
      rv_pkg::fn_ADD:  aluOf = alt ? rv_pkg::SUB : rv_pkg::ADD;
      rv_pkg::fn_SLL:  aluOf = rv_pkg::SLL;
      rv_pkg::fn_SLT:  aluOf = rv_pkg::SLT;
      rv_pkg::fn_SLTU: aluOf = rv_pkg::SLTU;
      rv_pkg::fn_XOR:  aluOf = rv_pkg::XOR;
      rv_pkg::fn_SR:   aluOf = alt ? rv_pkg::SRA : rv_pkg::SRL;
      rv_pkg::fn_OR:   aluOf = rv_pkg::OR;
      rv_pkg::fn_AND:  aluOf = rv_pkg::AND;
      default:         aluOf = rv_pkg::ADD;
    endcase
  endfunction

  always_comb begin
    dinst = '0;
    dinst.itype = rv_pkg::Unsupported;

    case (opcode)
      rv_pkg::op_LUI: begin
        dinst.itype = rv_pkg::LUI;
        dinst.dst = dst;
        dinst.dstValid = 1'b1;
        dinst.imm = immU;
      end

      rv_pkg::op_AUIPC: begin
        dinst.itype = rv_pkg::AUIPC;
        dinst.dst = dst;
        dinst.dstValid = 1'b1;
        dinst.imm = immU;
      end

      rv_pkg::op_OPIMM: begin
        dinst.itype = rv_pkg::OPIMM;
        dinst.src1 = src1;
        dinst.dst = dst;
        dinst.dstValid = 1'b1;
        dinst.imm = immI;
        // upper imm bits only carry funct7 for the shifts
        dinst.aluFunc = aluOf(funct3, (funct3 == rv_pkg::fn_SR) && funct7[5]);
        if (funct3 == rv_pkg::fn_SLL && funct7 != 7'b0000000) begin
          dinst.itype = rv_pkg::Unsupported;
        end
        if (funct3 == rv_pkg::fn_SR && funct7 != 7'b0000000 && funct7 != 7'b0100000) begin
          dinst.itype = rv_pkg::Unsupported;
        end
      end

      rv_pkg::op_OP: begin
        dinst.itype = rv_pkg::OP;
        dinst.src1 = src1;
        dinst.src2 = src2;
        dinst.dst = dst;
        dinst.dstValid = 1'b1;
        dinst.aluFunc = aluOf(funct3, funct7[5]);
        // alt funct7 only legal for SUB and SRA
        if (funct7 == 7'b0100000) begin
          if (funct3 != rv_pkg::fn_ADD && funct3 != rv_pkg::fn_SR) begin
            dinst.itype = rv_pkg::Unsupported;
          end
        end else if (funct7 != 7'b0000000) begin
          dinst.itype = rv_pkg::Unsupported;
        end
      end

      rv_pkg::op_BRANCH: begin
        dinst.itype = rv_pkg::BRANCH;
        dinst.src1 = src1;
        dinst.src2 = src2;
        dinst.imm = immB;
        case (funct3)
          rv_pkg::fn_BEQ:  dinst.brFunc = rv_pkg::EQ;
          rv_pkg::fn_BNE:  dinst.brFunc = rv_pkg::NEQ;
          rv_pkg::fn_BLT:  dinst.brFunc = rv_pkg::LT;
          rv_pkg::fn_BGE:  dinst.brFunc = rv_pkg::GE;
          rv_pkg::fn_BLTU: dinst.brFunc = rv_pkg::LTU;
          rv_pkg::fn_BGEU: dinst.brFunc = rv_pkg::GEU;
          default:         dinst.itype = rv_pkg::Unsupported;
        endcase
      end

      rv_pkg::op_JAL: begin
        dinst.itype = rv_pkg::JAL;
        dinst.dst = dst;
        dinst.dstValid = 1'b1;
        dinst.imm = immJ;
      end

      rv_pkg::op_JALR: begin
        if (inst[14:12] == 3'b000) begin
          dinst.itype = rv_pkg::JALR;
          dinst.src1 = src1;
          dinst.dst = dst;
          dinst.dstValid = 1'b1;
          dinst.imm = immI;
        end
      end

      rv_pkg::op_LOAD: begin
        dinst.itype = rv_pkg::LOAD;
        dinst.src1 = src1;
        dinst.dst = dst;
        dinst.dstValid = 1'b1;
        dinst.imm = immI;
        case (funct3)
          rv_pkg::fn_LB:  dinst.memFunc = rv_pkg::LB;
          rv_pkg::fn_LH:  dinst.memFunc = rv_pkg::LH;
          rv_pkg::fn_LW:  dinst.memFunc = rv_pkg::LW;
          rv_pkg::fn_LBU: dinst.memFunc = rv_pkg::LBU;
          rv_pkg::fn_LHU: dinst.memFunc = rv_pkg::LHU;
          default: begin
            dinst.itype = rv_pkg::Unsupported;
            dinst.dstValid = 1'b0;
          end
        endcase
      end

      rv_pkg::op_STORE: begin
        dinst.itype = rv_pkg::STORE;
        dinst.src1 = src1;
        dinst.src2 = src2;
        dinst.imm = immS;
        case (funct3)
          rv_pkg::fn_SB: dinst.memFunc = rv_pkg::SB;
          rv_pkg::fn_SH: dinst.memFunc = rv_pkg::SH;
          rv_pkg::fn_SW: dinst.memFunc = rv_pkg::SW;
          default:       dinst.itype = rv_pkg::Unsupported;
        endcase
      end

      // unknown opcodes keep the Unsupported default
      default: ;
    endcase
  end
endmodule

`default_nettype wire

// ==== logic/regFile.sv ====
`default_nettype none
`timescale 1ns/1ps

module regFile (
  input  wire           clk,
  input  wire           rstN,
  input  rv_pkg::RegIdx rdAddr1,
  input  rv_pkg::RegIdx rdAddr2,
  output rv_pkg::Word   rdData1,
  output rv_pkg::Word   rdData2,
  input  wire           wrEn,
  input  rv_pkg::RegIdx wrAddr,
  input  rv_pkg::Word   wrData
);
  rv_pkg::Word regs [32];

  assign rdData1 = regs[rdAddr1];
  assign rdData2 = regs[rdAddr2];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && wrAddr != '0) begin
      // x0 never takes a write
      regs[wrAddr] <= wrData;
    end
  end

  x0ReadsZero: assert property (@(posedge clk) disable iff (!rstN)
    (rdAddr1 == '0 -> rdData1 == '0) && (rdAddr2 == '0 -> rdData2 == '0));
endmodule

`default_nettype wire

// ==== logic/rvCore.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "rv_config.svh"

module rvCore (
  input  wire           clk,
  input  wire           rstN,
  input  rv_pkg::Word   inst,
  input  wire           instValid,
  output rv_pkg::Word   pc,
  output logic          wbValid,
  output rv_pkg::RegIdx wbDst,
  output rv_pkg::Word   wbData,
  output logic          illegal
);
  rv_pkg::DecodedInst dinst;
  rv_pkg::Word rs1Data;
  rv_pkg::Word rs2Data;
  rv_pkg::Word aluB;
  rv_pkg::AluFunc aluFunc;
  rv_pkg::Word aluOut;
  rv_pkg::Word loadData;
  rv_pkg::Word pcPlus4;
  rv_pkg::Word pcImm;
  rv_pkg::Word nextPc;
  rv_pkg::Word wbSel;
  logic brTaken;
  logic isUnsup;
  logic regWrEn;
  logic memWrEn;

  decoder i_decoder (.inst(inst), .dinst(dinst));

  regFile i_regFile (
    .clk(clk), .rstN(rstN),
    .rdAddr1(dinst.src1), .rdAddr2(dinst.src2),
    .rdData1(rs1Data), .rdData2(rs2Data),
    .wrEn(regWrEn), .wrAddr(dinst.dst), .wrData(wbSel)
  );

  // only OP uses rs2; everything else adds imm to rs1
  assign aluB = (dinst.itype == rv_pkg::OP) ? rs2Data : dinst.imm;
  assign aluFunc = (dinst.itype == rv_pkg::OP || dinst.itype == rv_pkg::OPIMM) ?
                   dinst.aluFunc : rv_pkg::ADD;

  alu i_alu (.a(rs1Data), .b(aluB), .func(aluFunc), .result(aluOut));

  dataMem i_dataMem (
    .clk(clk), .addr(aluOut), .wrData(rs2Data),
    .memFunc(dinst.memFunc), .wrEn(memWrEn), .rdData(loadData)
  );

  assign isUnsup = (dinst.itype == rv_pkg::Unsupported);
  assign regWrEn = instValid && dinst.dstValid && !isUnsup && dinst.dst != '0;
  assign memWrEn = instValid && dinst.itype == rv_pkg::STORE;
  assign pcPlus4 = pc + 32'd4;
  assign pcImm = pc + dinst.imm;

  always_comb begin
    case (dinst.brFunc)
      rv_pkg::EQ:  brTaken = rs1Data == rs2Data;
      rv_pkg::NEQ: brTaken = rs1Data != rs2Data;
      rv_pkg::LT:  brTaken = $signed(rs1Data) < $signed(rs2Data);
      rv_pkg::GE:  brTaken = $signed(rs1Data) >= $signed(rs2Data);
      rv_pkg::LTU: brTaken = rs1Data < rs2Data;
      rv_pkg::GEU: brTaken = rs1Data >= rs2Data;
      default:     brTaken = 1'b0;
    endcase
  end

  always_comb begin
    case (dinst.itype)
      rv_pkg::JAL:    nextPc = pcImm;
      rv_pkg::JALR:   nextPc = {aluOut[31:1], 1'b0};
      rv_pkg::BRANCH: nextPc = brTaken ? pcImm : pcPlus4;
      default:        nextPc = pcPlus4;
    endcase
  end

  always_comb begin
    case (dinst.itype)
      rv_pkg::LUI:   wbSel = dinst.imm;
      rv_pkg::AUIPC: wbSel = pcImm;
      rv_pkg::JAL,
      rv_pkg::JALR:  wbSel = pcPlus4;
      rv_pkg::LOAD:  wbSel = loadData;
      default:       wbSel = aluOut;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= `RV_RESET_PC;
      wbValid <= 1'b0;
      illegal <= 1'b0;
    end else begin
      wbValid <= regWrEn;
      illegal <= instValid && isUnsup;
      if (instValid) begin
        pc <= nextPc;
      end
    end
  end

  // report payload, qualified by wbValid
  always_ff @(posedge clk) begin
    if (regWrEn) begin
      wbDst <= dinst.dst;
      wbData <= wbSel;
    end
  end

  wbNotX0: assert property (@(posedge clk) disable iff (!rstN) wbValid |-> wbDst != '0);
endmodule

`default_nettype wire

// ==== logic/rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// pc value after reset
`define RV_RESET_PC 32'h0000_0000

// data RAM depth in words, power of two
`define RV_DMEM_WORDS 256

`endif

// ==== logic/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  typedef logic [31:0] Word;
  typedef logic [4:0] RegIdx;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    op_LUI    = 7'b0110111,
    op_AUIPC  = 7'b0010111,
    op_OP     = 7'b0110011,
    op_OPIMM  = 7'b0010011,
    op_BRANCH = 7'b1100011,
    op_JAL    = 7'b1101111,
    op_JALR   = 7'b1100111,
    op_LOAD   = 7'b0000011,
    op_STORE  = 7'b0100011
  } Opcode;

  // funct3 codes of the integer ops
  typedef enum logic [2:0] {
    fn_ADD  = 3'b000,
    fn_SLL  = 3'b001,
    fn_SLT  = 3'b010,
    fn_SLTU = 3'b011,
    fn_XOR  = 3'b100,
    fn_SR   = 3'b101,
    fn_OR   = 3'b110,
    fn_AND  = 3'b111
  } Funct3;

  // branch and memory names share the same 3-bit codes
  localparam Funct3 fn_BEQ  = fn_ADD;
  localparam Funct3 fn_BNE  = fn_SLL;
  localparam Funct3 fn_BLT  = fn_XOR;
  localparam Funct3 fn_BGE  = fn_SR;
  localparam Funct3 fn_BLTU = fn_OR;
  localparam Funct3 fn_BGEU = fn_AND;
  localparam Funct3 fn_LB   = fn_ADD;
  localparam Funct3 fn_LH   = fn_SLL;
  localparam Funct3 fn_LW   = fn_SLT;
  localparam Funct3 fn_LBU  = fn_XOR;
  localparam Funct3 fn_LHU  = fn_SR;
  localparam Funct3 fn_SB   = fn_ADD;
  localparam Funct3 fn_SH   = fn_SLL;
  localparam Funct3 fn_SW   = fn_SLT;

  typedef enum logic [3:0] {
    LUI, AUIPC, OP, OPIMM, BRANCH, JAL, JALR, LOAD, STORE, Unsupported
  } IType;

  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA
  } AluFunc;

  typedef enum logic [2:0] {EQ, NEQ, LT, GE, LTU, GEU} BrFunc;

  typedef enum logic [2:0] {LW, LH, LB, LHU, LBU, SW, SH, SB} MemFunc;

  typedef struct packed {
    IType   itype;
    AluFunc aluFunc;
    BrFunc  brFunc;
    MemFunc memFunc;
    RegIdx  src1;
    RegIdx  src2;
    RegIdx  dst;
    logic   dstValid;
    Word    imm;
  } DecodedInst;

endpackage

`default_nettype wire

// ==== test/rvModel.svh ====
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

`include "rv_config.svh"

// architectural state of the reference model
rv_pkg::Word mRegs [32];
rv_pkg::Word mMem [`RV_DMEM_WORDS];
rv_pkg::Word mPc;

task automatic modelReset();
  for (int i = 0; i < 32; i++) begin
    mRegs[i] = '0;
  end
  mPc = `RV_RESET_PC;
endtask

// integer op by raw funct3, alt selects SUB or SRA
function automatic rv_pkg::Word aluModel(input logic [2:0] f3, input logic alt,
                                         input rv_pkg::Word a, input rv_pkg::Word b);
  case (f3)
    3'd0: aluModel = alt ? a - b : a + b;
    3'd1: aluModel = a << b[4:0];
    3'd2: aluModel = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: aluModel = (a < b) ? 32'd1 : 32'd0;
    3'd4: aluModel = a ^ b;
    3'd6: aluModel = a | b;
    3'd7: aluModel = a & b;
    default: begin
      if (alt) begin
        aluModel = $signed(a) >>> b[4:0];
      end else begin
        aluModel = a >> b[4:0];
      end
    end
  endcase
endfunction

// one retired instruction: predicts the report and updates the state
task automatic modelStep(input rv_pkg::Word word, output logic expWb,
                         output rv_pkg::RegIdx expDst, output rv_pkg::Word expData,
                         output logic expIll);
  rv_pkg::Word rs1;
  rv_pkg::Word rs2;
  rv_pkg::Word immI;
  rv_pkg::Word immS;
  rv_pkg::Word addr;
  rv_pkg::Word cur;
  rv_pkg::Word res;
  rv_pkg::Word nextPc;
  logic [2:0] f3;
  logic [6:0] f7;
  logic [7:0] b8;
  logic [15:0] h16;
  logic legal;
  logic writes;
  logic taken;
  int idx;
  f3 = word[14:12];
  f7 = word[31:25];
  rs1 = mRegs[word[19:15]];
  rs2 = mRegs[word[24:20]];
  immI = {{20{word[31]}}, word[31:20]};
  immS = {{20{word[31]}}, word[31:25], word[11:7]};
  legal = 1'b1;
  writes = 1'b1;
  taken = 1'b0;
  res = '0;
  nextPc = mPc + 4;
  case (word[6:0])
    rv_pkg::op_LUI:   res = {word[31:12], 12'b0};
    rv_pkg::op_AUIPC: res = mPc + {word[31:12], 12'b0};
    rv_pkg::op_OP: begin
      legal = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      res = aluModel(f3, f7[5], rs1, rs2);
    end
    rv_pkg::op_OPIMM: begin
      // funct7 only matters for the shifts
      legal = (f3 != 3'd1 || f7 == 7'h00) &&
              (f3 != 3'd5 || f7 == 7'h00 || f7 == 7'h20);
      res = aluModel(f3, f3 == 3'd5 && f7[5], rs1, immI);
    end
    rv_pkg::op_BRANCH: begin
      writes = 1'b0;
      legal = f3 != 3'd2 && f3 != 3'd3;
      case (f3)
        3'd0: taken = rs1 == rs2;
        3'd1: taken = rs1 != rs2;
        3'd4: taken = $signed(rs1) < $signed(rs2);
        3'd5: taken = $signed(rs1) >= $signed(rs2);
        3'd6: taken = rs1 < rs2;
        3'd7: taken = rs1 >= rs2;
        default: taken = 1'b0;
      endcase
      if (taken) begin
        nextPc = mPc + {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
      end
    end
    rv_pkg::op_JAL: begin
      res = mPc + 4;
      nextPc = mPc + {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    end
    rv_pkg::op_JALR: begin
      legal = f3 == 3'd0;
      res = mPc + 4;
      if (legal) begin
        nextPc = (rs1 + immI) & ~32'd1;
      end
    end
    rv_pkg::op_LOAD: begin
      addr = rs1 + immI;
      idx = (addr >> 2) % `RV_DMEM_WORDS;
      cur = mMem[idx] >> {addr[1:0], 3'b000};
      b8 = cur[7:0];
      h16 = addr[1] ? mMem[idx][31:16] : mMem[idx][15:0];
      case (f3)
        3'd0: res = {{24{b8[7]}}, b8};
        3'd1: res = {{16{h16[15]}}, h16};
        3'd2: res = mMem[idx];
        3'd4: res = {24'b0, b8};
        3'd5: res = {16'b0, h16};
        default: legal = 1'b0;
      endcase
    end
    rv_pkg::op_STORE: begin
      writes = 1'b0;
      addr = rs1 + immS;
      idx = (addr >> 2) % `RV_DMEM_WORDS;
      legal = f3 <= 3'd2;
      cur = mMem[idx];
      case (f3)
        3'd0: cur[8*addr[1:0] +: 8] = rs2[7:0];
        3'd1: cur[16*addr[1] +: 16] = rs2[15:0];
        3'd2: cur = rs2;
        default: ;
      endcase
      if (legal) begin
        mMem[idx] = cur;
      end
    end
    default: legal = 1'b0;
  endcase
  expIll = !legal;
  expWb = legal && writes && word[11:7] != 5'd0;
  expDst = word[11:7];
  expData = res;
  if (expWb) begin
    mRegs[word[11:7]] = res;
  end
  mPc = nextPc;
endtask

`endif

// ==== test/rvCoreTb.sv ====
`default_nettype none
`timescale 1ns/1ps
`include "rv_config.svh"

module rvCoreTb;
  localparam int AluCount = 400;
  localparam int PairCount = 200;
  localparam int CtrlCount = 300;
  localparam int BadCount = 100;
  // ram fill costs three instructions per word plus idle cycles
  localparam int TotalInst = 20 + AluCount / 4 + 3 * `RV_DMEM_WORDS + AluCount +
                             2 * PairCount + CtrlCount + BadCount;

  logic clk;
  logic rstN;
  rv_pkg::Word inst;
  logic instValid;
  rv_pkg::Word pc;
  logic wbValid;
  rv_pkg::RegIdx wbDst;
  rv_pkg::Word wbData;
  logic illegal;

  logic [31:0] lcgState;
  int checks;
  int errors;
  int testStartErrors;

  rvCore i_dut (
    .clk(clk), .rstN(rstN), .inst(inst), .instValid(instValid), .pc(pc),
    .wbValid(wbValid), .wbDst(wbDst), .wbData(wbData), .illegal(illegal)
  );

  `include "rvModel.svh"

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(TotalInst * 10 + 2000);
    $display("watchdog: simulation ran past its time limit");
    $display("TEST FAIL");
    $finish;
  end

  function automatic rv_pkg::Word lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // the low LCG bits repeat quickly so use the upper ones
  function automatic int randBelow(input int n);
    return int'(lcgNext() >> 8) % n;
  endfunction

  function automatic rv_pkg::RegIdx randReg();
    return rv_pkg::RegIdx'(randBelow(32));
  endfunction

  function automatic rv_pkg::Funct3 randF3();
    rv_pkg::Word r;
    r = lcgNext();
    return rv_pkg::Funct3'(r[20:18]);
  endfunction

  task automatic checkWord(input string name, input rv_pkg::Word got, input rv_pkg::Word exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkReg(input string name, input rv_pkg::RegIdx got,
                          input rv_pkg::RegIdx exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got x%0d expected x%0d", $time, name, got, exp);
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // drive one word and compare the report one cycle later
  task automatic runInst(input rv_pkg::Word word);
    logic expWb;
    logic expIll;
    rv_pkg::RegIdx expDst;
    rv_pkg::Word expData;
    modelStep(word, expWb, expDst, expData, expIll);
    inst = word;
    instValid = 1'b1;
    @(posedge clk);
    #1;
    instValid = 1'b0;
    checkBit("illegal", illegal, expIll);
    checkBit("wbValid", wbValid, expWb);
    if (expWb) begin
      checkReg("wbDst", wbDst, expDst);
      checkWord("wbData", wbData, expData);
    end
    checkWord("pc", pc, mPc);
  endtask

  task automatic idleCycle();
    instValid = 1'b0;
    @(posedge clk);
    #1;
    checkBit("illegal", illegal, 1'b0);
    checkBit("wbValid", wbValid, 1'b0);
    checkWord("pc", pc, mPc);
  endtask

  task automatic startTest();
    testStartErrors = errors;
  endtask

  task automatic reportTest(input string name, input int count);
    $display("%-10s %0d instructions, %0d errors", name, count, errors - testStartErrors);
  endtask

  // LUI, ADDI, SW per word so every lane holds known data
  task automatic fillRam();
    rv_pkg::Word val;
    logic [11:0] off;
    for (int w = 0; w < `RV_DMEM_WORDS; w++) begin
      val = 32'(w + 1) * 32'h9e37_79b1;
      off = 12'(4 * w);
      runInst({val[31:12] + {19'b0, val[11]}, 5'd5, rv_pkg::op_LUI});
      runInst({val[11:0], 5'd5, rv_pkg::fn_ADD, 5'd5, rv_pkg::op_OPIMM});
      runInst({off[11:5], 5'd5, 5'd0, rv_pkg::fn_SW, off[4:0], rv_pkg::op_STORE});
    end
  endtask

  function automatic rv_pkg::Word aluInst();
    rv_pkg::Word r;
    rv_pkg::Funct3 f3;
    rv_pkg::RegIdx rd;
    logic alt;
    r = lcgNext();
    f3 = randF3();
    rd = randReg();
    alt = randBelow(2) == 1;
    case (randBelow(4))
      0: begin
        alt = alt && (f3 == rv_pkg::fn_ADD || f3 == rv_pkg::fn_SR);
        aluInst = {alt ? 7'h20 : 7'h00, r[24:15], f3, rd, rv_pkg::op_OP};
      end
      1: begin
        if (f3 == rv_pkg::fn_SLL) begin
          r[31:25] = 7'h00;
        end
        if (f3 == rv_pkg::fn_SR) begin
          r[31:25] = alt ? 7'h20 : 7'h00;
        end
        aluInst = {r[31:15], f3, rd, rv_pkg::op_OPIMM};
      end
      2: aluInst = {r[31:12], rd, rv_pkg::op_LUI};
      default: aluInst = {r[31:12], rd, rv_pkg::op_AUIPC};
    endcase
    if (randBelow(20) == 0) begin
      aluInst = lcgNext();
    end
  endfunction

  // store then load at the same address with independent widths
  task automatic memPair();
    rv_pkg::Word r;
    rv_pkg::Funct3 stF3;
    rv_pkg::Funct3 ldF3;
    rv_pkg::RegIdx base;
    logic [11:0] imm;
    r = lcgNext();
    imm = r[27:16];
    base = (randBelow(2) == 0) ? 5'd0 : randReg();
    case (randBelow(3))
      0: stF3 = rv_pkg::fn_SB;
      1: stF3 = rv_pkg::fn_SH;
      default: stF3 = rv_pkg::fn_SW;
    endcase
    case (randBelow(5))
      0: ldF3 = rv_pkg::fn_LB;
      1: ldF3 = rv_pkg::fn_LH;
      2: ldF3 = rv_pkg::fn_LW;
      3: ldF3 = rv_pkg::fn_LBU;
      default: ldF3 = rv_pkg::fn_LHU;
    endcase
    runInst({imm[11:5], randReg(), base, stF3, imm[4:0], rv_pkg::op_STORE});
    runInst({imm, base, ldF3, randReg(), rv_pkg::op_LOAD});
  endtask

  function automatic rv_pkg::Word ctrlInst();
    rv_pkg::Word r;
    rv_pkg::Funct3 f3;
    rv_pkg::RegIdx rs1;
    rv_pkg::RegIdx rs2;
    r = lcgNext();
    rs1 = randReg();
    // equal operands now and then
    rs2 = (randBelow(4) == 0) ? rs1 : randReg();
    case (randBelow(6))
      0: f3 = rv_pkg::fn_BEQ;
      1: f3 = rv_pkg::fn_BNE;
      2: f3 = rv_pkg::fn_BLT;
      3: f3 = rv_pkg::fn_BGE;
      4: f3 = rv_pkg::fn_BLTU;
      default: f3 = rv_pkg::fn_BGEU;
    endcase
    case (randBelow(4))
      0, 1: ctrlInst = {r[31:25], rs2, rs1, f3, r[11:7], rv_pkg::op_BRANCH};
      2: ctrlInst = {r[31:12], randReg(), rv_pkg::op_JAL};
      default: ctrlInst = {r[31:20], rs1, rv_pkg::fn_ADD, randReg(), rv_pkg::op_JALR};
    endcase
  endfunction

  function automatic rv_pkg::Word badInst();
    rv_pkg::Word r;
    rv_pkg::Funct3 f3;
    r = lcgNext();
    f3 = randF3();
    if (f3 == rv_pkg::fn_ADD || f3 == rv_pkg::fn_SR) begin
      f3 = rv_pkg::fn_OR;
    end
    case (randBelow(9))
      0: badInst = {r[31:26], 1'b1, r[24:7], rv_pkg::op_OP};
      1: badInst = {7'h20, r[24:15], f3, r[11:7], rv_pkg::op_OP};
      2: badInst = {r[31:26], 1'b1, r[24:15], rv_pkg::fn_SLL, r[11:7], rv_pkg::op_OPIMM};
      3: badInst = {r[31:15], 2'b01, r[12], r[11:7], rv_pkg::op_BRANCH};
      4: badInst = {r[31:15], r[13] ? rv_pkg::fn_SLTU : rv_pkg::fn_AND, r[11:7],
                    rv_pkg::op_LOAD};
      5: badInst = {r[31:15], 1'b1, r[13:12], r[11:7], rv_pkg::op_STORE};
      6: badInst = {r[31:15], r[14:13], 1'b1, r[11:7], rv_pkg::op_JALR};
      7: badInst = {r[31:7], r[6:2], 2'b01};
      default: badInst = {r[31:7], 7'b1110011};
    endcase
  endfunction

  initial begin
    rstN = 1'b0;
    inst = '0;
    instValid = 1'b0;
    lcgState = 32'hebae9a8b;
    checks = 0;
    errors = 0;
    modelReset();
    repeat (4) @(posedge clk);
    #1;
    rstN = 1'b1;

    startTest();
    checkWord("pc", pc, `RV_RESET_PC);
    repeat (4) idleCycle();
    reportTest("reset", 0);

    startTest();
    fillRam();
    reportTest("ramFill", 3 * `RV_DMEM_WORDS);

    startTest();
    repeat (AluCount) begin
      runInst(aluInst());
      // idle gaps after writebacks, the report must drop
      if (randBelow(8) == 0) begin
        idleCycle();
      end
    end
    reportTest("aluOps", AluCount);

    startTest();
    repeat (PairCount) memPair();
    reportTest("loadStore", 2 * PairCount);

    startTest();
    repeat (CtrlCount) runInst(ctrlInst());
    reportTest("control", CtrlCount);

    startTest();
    repeat (BadCount) runInst(badInst());
    idleCycle();
    reportTest("illegal", BadCount);

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end
endmodule

`default_nettype wire
